//--- flist.f
clk_monitor_pkg.sv
timebase.sv
edge_rate_counter.sv
rate_monitor.sv
adc_level_trigger.sv
openadc_monitor_top.sv
tb_openadc_monitor.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f \
   --top-module tb_openadc_monitor -Mdir obj_dir &&
./obj_dir/Vtb_openadc_monitor | tee /dev/stderr | grep -F '>>> PASS' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- tb_openadc_monitor.sv
`timescale 1ns/1ns

module tb_openadc_monitor
   import clk_monitor_pkg::*;
();

   localparam int GATE_CYCLES = 2 ** (GATE_BITS + 1);
   localparam int FIRST_GATE  = 2 ** GATE_BITS + 1;  // gate bit rises, strobe one cycle later
   localparam int MIN_GATES   = 10;
   localparam int GAIN_WINDOW = 256;

   logic                  clk_usb;
   logic                  reset;
   monitor_cfg_t          cfg;
   logic [NUM_CLK_CH-1:0] mon_clk;
   sample_t               adc_data;
   logic                  arm;
   rate_vec_t             rates;
   logic                  clk_change;
   logic                  led_armed;
   logic                  led_capture;
   logic                  measure;
   logic                  trigger;
   logic                  gain_pwm;

   // monitored clock stimulus
   int half_period [NUM_CLK_CH];
   int down_cnt [NUM_CLK_CH];
   int edges [NUM_CLK_CH];      // rising edges driven in the current gate period
   int exp_rate [NUM_CLK_CH];
   int ch0_fixed;               // 0 lets channel 0 pick random periods
   int gate_age;
   int gate_gap;                // cycles since reset or the last strobe
   int gate_spacing;
   int gates_seen;
   int arm_pulses;
   int trig_total;
   bit change_seen;

   // reference model
   sample_t m_tcnt;
   sample_t m_pre;
   sample_t m_cmp;
   bit      m_allowed;
   bit      m_trig;
   bit      m_arm_r;
   bit      m_flag;
   int      m_prev_rate;
   bit      gain_hist [GAIN_WINDOW];
   int      gain_idx;
   int      gain_sum;
   int      gain_settle;
   gain_t   gain_last;

   openadc_monitor_top dut_i (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .cfg_i         (cfg),
      .mon_clk_i     (mon_clk),
      .adc_data_i    (adc_data),
      .arm_i         (arm),
      .rates_o       (rates),
      .clk_change_o  (clk_change),
      .led_armed_o   (led_armed),
      .led_capture_o (led_capture),
      .measure_o     (measure),
      .trigger_o     (trigger),
      .gain_o        (gain_pwm)
   );

   always #10 clk_usb = ~clk_usb;

   function automatic bit crosses_level(input sample_t s, input sample_t level);
      if (level[SAMPLE_BITS-1]) begin
         return s > level;   // msb set fires above
      end else begin
         return s < level;
      end
   endfunction

   function automatic int abs_diff(input int a, input int b);
      return (a > b) ? a - b : b - a;
   endfunction

   task automatic stop_run();
      $display(">>> FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic expect_equal(input string what, input int got, input int exp);
      assert (got == exp) else begin
         $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
         stop_run();
      end
   endtask

   // advance the model across the rising edge that just passed
   task automatic update_model();
      bit trig_next;
      trig_next = m_allowed && !m_trig && crosses_level(m_cmp, cfg.trig_level);
      m_cmp = m_pre;
      m_pre = cfg.use_adc ? adc_data : m_tcnt;
      if (reset) begin
         m_tcnt      = '0;
         m_allowed   = 1'b0;
         m_trig      = 1'b0;
         m_arm_r     = 1'b0;
         m_flag      = 1'b0;
         m_prev_rate = 0;
         gate_age    = 99;
         gate_gap    = 0;
         gain_settle = 0;
         gain_last   = cfg.gain;
         return;
      end
      if (!m_allowed && arm && !m_arm_r) begin
         m_allowed = 1'b1;
      end else if (m_allowed && m_trig) begin
         m_allowed = 1'b0;
      end
      m_arm_r = arm;
      m_trig  = trig_next;
      m_tcnt  = m_tcnt + 1'b1;

      gate_gap++;
      if (measure) begin
         gates_seen++;
         gate_age     = 0;
         gate_spacing = gate_gap;
         gate_gap     = 0;
         for (int ch = 0; ch < NUM_CLK_CH; ch++) begin
            exp_rate[ch]    = edges[ch];
            edges[ch]       = 0;
            half_period[ch] = (ch == 0 && ch0_fixed != 0) ? ch0_fixed : $urandom_range(9, 2);
         end
      end else if (gate_age < 99) begin
         gate_age++;
      end

      // change flag updates two cycles after the strobe
      if (cfg.monitor_disable) begin
         m_flag = 1'b0;
      end else if (gate_age == 2 && m_prev_rate != 0 && exp_rate[0] != 0
                   && abs_diff(exp_rate[0], m_prev_rate) > int'(cfg.change_limit)) begin
         m_flag = 1'b1;
      end
      if (gate_age == 2) begin
         m_prev_rate = exp_rate[0];
      end

      gain_sum            = gain_sum - int'(gain_hist[gain_idx]);
      gain_hist[gain_idx] = gain_pwm;
      gain_sum            = gain_sum + int'(gain_pwm);
      gain_idx            = (gain_idx + 1) % GAIN_WINDOW;
      if (cfg.gain != gain_last) begin
         gain_last   = cfg.gain;
         gain_settle = 0;
      end else if (gain_settle < 1000) begin
         gain_settle++;
      end
   endtask

   task automatic check_outputs();
      expect_equal("trigger_o", trigger, m_trig);
      expect_equal("clk_change_o", clk_change, m_flag);
      if (m_flag) begin
         expect_equal("led_capture_o against led_armed_o", led_capture, led_armed);
      end else if (cfg.led_select == LED_STATUS) begin
         expect_equal("led_armed_o", led_armed, m_allowed);
         expect_equal("led_capture_o", led_capture, m_trig);
      end
      if (trigger) begin
         arm_pulses++;
         trig_total++;
      end
      assert (arm_pulses <= 1) else begin
         $display("mismatch at %0t: second trigger pulse after one arming edge", $time);
         stop_run();
      end
      if (clk_change) begin
         change_seen = 1'b1;
      end
      if (gate_age == 0) begin
         expect_equal("measure_o spacing", gate_spacing,
                      (gates_seen == 1) ? FIRST_GATE : GATE_CYCLES);
      end
      if (gate_age == 1) begin
         for (int ch = 0; ch < NUM_CLK_CH; ch++) begin
            assert (abs_diff(rates[ch], exp_rate[ch]) <= 1) else begin
               $display("mismatch at %0t: rate of channel %0d is %0d, expected %0d +/- 1",
                        $time, ch, rates[ch], exp_rate[ch]);
               stop_run();
            end
         end
      end
      if (gain_settle >= GAIN_WINDOW + 2) begin
         expect_equal("gain_o high cycles per 256", gain_sum, cfg.gain);
      end
   endtask

   task automatic drive_clocks();
      if (reset) begin
         return;
      end
      for (int ch = 0; ch < NUM_CLK_CH; ch++) begin
         if (down_cnt[ch] == 0) begin
            mon_clk[ch]  = ~mon_clk[ch];
            if (mon_clk[ch]) begin
               edges[ch]++;
            end
            down_cnt[ch] = half_period[ch] - 1;
         end else begin
            down_cnt[ch]--;
         end
      end
   endtask

   task automatic tick();
      @(negedge clk_usb);
      update_model();
      if (!reset) begin
         check_outputs();
      end
      drive_clocks();
   endtask

   task automatic run_random(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         tick();
         adc_data = sample_t'($urandom);
         if ($urandom_range(7, 0) == 0) begin
            arm = ~arm;
            if (arm) begin
               arm_pulses = 0;   // new arming edge
            end
         end
      end
   endtask

   task automatic wait_for_gate();
      int waited;
      waited = 0;
      tick();
      while (!measure) begin
         waited++;
         assert (waited <= GATE_CYCLES + 16) else begin
            $display("no measure strobe seen within %0d cycles", waited);
            stop_run();
         end
         tick();
      end
   endtask

   initial begin
      clk_usb             = 1'b0;
      reset               = 1'b1;
      mon_clk             = '0;
      adc_data            = '0;
      arm                 = 1'b0;
      cfg.led_select      = LED_STATUS;
      cfg.monitor_disable = 1'b1;
      cfg.change_limit    = rate_t'(40);
      cfg.gain            = gain_t'(64);
      cfg.trig_level      = sample_t'(12'h800);
      cfg.use_adc         = 1'b1;
      void'($urandom(43));
      for (int ch = 0; ch < NUM_CLK_CH; ch++) begin
         half_period[ch] = $urandom_range(9, 2);
         down_cnt[ch]    = 0;
         edges[ch]       = 0;
         exp_rate[ch]    = 0;
      end
      ch0_fixed    = 0;
      gates_seen   = 0;
      gate_gap     = 0;
      gate_spacing = 0;
      arm_pulses   = 0;
      trig_total   = 0;
      change_seen  = 1'b0;
      m_tcnt       = '0;
      m_pre        = '0;
      m_cmp        = '0;
      gain_idx     = 0;
      gain_sum     = 0;
      gain_last    = cfg.gain;
      gate_age     = 99;

      repeat (2) tick();
      reset = 1'b0;

      // adc input with random levels of both signs
      for (int r = 0; r < 6; r++) begin
         cfg.gain       = gain_t'($urandom);
         cfg.trig_level = sample_t'($urandom);
         run_random(600);
      end

      // internal ramp as sample source
      cfg.use_adc = 1'b0;
      for (int r = 0; r < 4; r++) begin
         cfg.gain       = gain_t'($urandom);
         cfg.trig_level = sample_t'($urandom);
         run_random(1500);
      end
      cfg.use_adc = 1'b1;
      arm         = 1'b0;

      // steady external clock, then a sharp step in its rate
      ch0_fixed = 4;
      repeat (3) wait_for_gate();
      repeat (4) tick();
      cfg.monitor_disable = 1'b0;
      repeat (2) wait_for_gate();
      ch0_fixed = 8;
      repeat (2) wait_for_gate();
      repeat (4) tick();
      assert (m_flag && change_seen) else begin
         $display("clock change flag was not raised by the rate step");
         stop_run();
      end
      cfg.monitor_disable = 1'b1;
      repeat (4) tick();

      if (gates_seen >= MIN_GATES && trig_total > 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         $display("too little activity: %0d measure strobes, %0d triggers",
                  gates_seen, trig_total);
         stop_run();
      end
   end

endmodule

//--- openadc_monitor_top.sv
`timescale 1ns/1ns

module openadc_monitor_top
   import clk_monitor_pkg::*;
(
   input  logic                  clk_usb,
   input  logic                  reset,
   input  monitor_cfg_t          cfg_i,
   input  logic [NUM_CLK_CH-1:0] mon_clk_i,
   input  sample_t               adc_data_i,
   input  logic                  arm_i,
   output rate_vec_t             rates_o,
   output logic                  clk_change_o,
   output logic                  led_armed_o,
   output logic                  led_capture_o,
   output logic                  measure_o,
   output logic                  trigger_o,
   output logic                  gain_o
);

   logic                  tb_heartbeat;
   logic                  flash;
   logic [NUM_CLK_CH-1:0] ch_heartbeat;
   logic                  armed;

   timebase u_timebase (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .gain_i      (cfg_i.gain),
      .gate_o      (measure_o),
      .heartbeat_o (tb_heartbeat),
      .flash_o     (flash),
      .gain_pwm_o  (gain_o)
   );

   // clocks are sampled as data in clk_usb
   for (genvar ch = 0; ch < NUM_CLK_CH; ch++) begin : g_rate
      edge_rate_counter u_counter (
         .clk_usb      (clk_usb),
         .reset        (reset),
         .clk_sample_i (mon_clk_i[ch]),
         .gate_i       (measure_o),
         .rate_o       (rates_o[ch]),
         .heartbeat_o  (ch_heartbeat[ch])
      );
   end

   rate_monitor u_rate_monitor (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .cfg_i          (cfg_i),
      .gate_i         (measure_o),
      .rates_i        (rates_o),
      .ch_heartbeat_i (ch_heartbeat),
      .tb_heartbeat_i (tb_heartbeat),
      .flash_i        (flash),
      .armed_i        (armed),
      .trigger_i      (trigger_o),
      .clk_change_o   (clk_change_o),
      .led_armed_o    (led_armed_o),
      .led_capture_o  (led_capture_o)
   );

   adc_level_trigger u_adc_trigger (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .cfg_i      (cfg_i),
      .adc_data_i (adc_data_i),
      .arm_i      (arm_i),
      .armed_o    (armed),
      .trigger_o  (trigger_o)
   );

endmodule

//--- adc_level_trigger.sv
`timescale 1ns/1ns

module adc_level_trigger
   import clk_monitor_pkg::*;
(
   input  logic         clk_usb,
   input  logic         reset,
   input  monitor_cfg_t cfg_i,
   input  sample_t      adc_data_i,
   input  logic         arm_i,
   output logic         armed_o,
   output logic         trigger_o
);

   sample_t     test_cnt;
   sample_t     sample_pre;
   sample_t     sample_cmp;    // compare register, two cycles after the input
   logic        level_hit;
   logic        arm_r;
   logic        arm_rise;
   trig_state_e state;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         test_cnt <= '0;
      end else begin
         test_cnt <= test_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk_usb) begin
      sample_pre <= cfg_i.use_adc ? adc_data_i : test_cnt;
      sample_cmp <= sample_pre;
   end

   // level msb set: fire above, else fire below
   assign level_hit = cfg_i.trig_level[SAMPLE_BITS-1] ? (sample_cmp > cfg_i.trig_level)
                                                      : (sample_cmp < cfg_i.trig_level);

   assign arm_rise = arm_i & ~arm_r;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         arm_r     <= 1'b0;
         state     <= TRIG_IDLE;
         trigger_o <= 1'b0;
      end else begin
         arm_r <= arm_i;

         // state still reads allowed during the pulse, so mask the repeat
         trigger_o <= (state == TRIG_ALLOWED) && !trigger_o && level_hit;

         case (state)
            TRIG_IDLE: begin
               if (arm_rise) state <= TRIG_ALLOWED;
            end
            TRIG_ALLOWED: begin
               if (trigger_o) state <= TRIG_IDLE;
            end
            default: state <= TRIG_IDLE;
         endcase
      end
   end

   assign armed_o = (state == TRIG_ALLOWED);

   a_trig_one_shot: assert property (
      @(posedge clk_usb) disable iff (reset)
      trigger_o |=> !trigger_o
   ) else $error("trigger pulse longer than one cycle");

endmodule

//--- rate_monitor.sv
`timescale 1ns/1ns

module rate_monitor
   import clk_monitor_pkg::*;
(
   input  logic                  clk_usb,
   input  logic                  reset,
   input  monitor_cfg_t          cfg_i,
   input  logic                  gate_i,
   input  rate_vec_t             rates_i,
   input  logic [NUM_CLK_CH-1:0] ch_heartbeat_i,
   input  logic                  tb_heartbeat_i,
   input  logic                  flash_i,
   input  logic                  armed_i,
   input  logic                  trigger_i,
   output logic                  clk_change_o,
   output logic                  led_armed_o,
   output logic                  led_capture_o
);

   logic  gate_d;        // rates are valid one cycle after the gate
   rate_t ext_rate_prev;
   rate_t ext_rate_new;
   rate_t ext_diff;
   logic  ext_jump;

   assign ext_rate_new = rates_i[0];
   assign ext_diff     = (ext_rate_new > ext_rate_prev) ? ext_rate_new - ext_rate_prev
                                                        : ext_rate_prev - ext_rate_new;
   // ignore a stopped clock on either side
   assign ext_jump     = (ext_rate_prev != '0) && (ext_rate_new != '0)
                         && (ext_diff > cfg_i.change_limit);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gate_d        <= 1'b0;
         ext_rate_prev <= '0;
      end else begin
         gate_d <= gate_i;
         if (gate_d) begin
            ext_rate_prev <= ext_rate_new;
         end
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         clk_change_o <= 1'b0;
      end else if (cfg_i.monitor_disable) begin
         clk_change_o <= 1'b0;
      end else if (gate_d && ext_jump) begin
         clk_change_o <= 1'b1;   // sticky
      end
   end

   always_comb begin
      if (clk_change_o) begin
         led_armed_o   = flash_i;
         led_capture_o = flash_i;
      end else begin
         case (cfg_i.led_select)
            LED_TIMEBASE: begin
               led_armed_o   = tb_heartbeat_i;
               led_capture_o = ch_heartbeat_i[0];
            end
            LED_FEEDBACK: begin
               led_armed_o   = ch_heartbeat_i[1];
               led_capture_o = ch_heartbeat_i[0];
            end
            LED_PLL: begin
               led_armed_o   = ch_heartbeat_i[2];
               led_capture_o = clk_change_o;
            end
            default: begin
               led_armed_o   = armed_i;
               led_capture_o = trigger_i;
            end
         endcase
      end
   end

   a_disable_clears: assert property (
      @(posedge clk_usb) disable iff (reset)
      cfg_i.monitor_disable |=> !clk_change_o
   ) else $error("clock change flag set while monitor disabled");

endmodule

//--- edge_rate_counter.sv
`timescale 1ns/1ns

module edge_rate_counter
   import clk_monitor_pkg::*;
(
   input  logic  clk_usb,
   input  logic  reset,
   input  logic  clk_sample_i,
   input  logic  gate_i,
   output rate_t rate_o,
   output logic  heartbeat_o
);

   logic            sync_1;
   logic            sync_2;
   logic            sync_prev;
   logic            rise;
   logic [HB_BIT:0] hb_cnt;
   rate_t           gate_cnt;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sync_1    <= 1'b0;
         sync_2    <= 1'b0;
         sync_prev <= 1'b0;
      end else begin
         sync_1    <= clk_sample_i;
         sync_2    <= sync_1;
         sync_prev <= sync_2;
      end
   end

   assign rise = sync_2 & ~sync_prev;

   // free running, only for the led
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         hb_cnt <= '0;
      end else if (rise) begin
         hb_cnt <= hb_cnt + 1'b1;
      end
   end

   assign heartbeat_o = hb_cnt[HB_BIT];

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gate_cnt <= '0;
         rate_o   <= '0;
      end else if (gate_i) begin
         rate_o   <= gate_cnt;
         gate_cnt <= rate_t'(rise);   // edge in the gate cycle opens the next period
      end else begin
         gate_cnt <= gate_cnt + rate_t'(rise);
      end
   end

endmodule

//--- timebase.sv
`timescale 1ns/1ns

module timebase
   import clk_monitor_pkg::*;
(
   input  logic  clk_usb,
   input  logic  reset,
   input  gain_t gain_i,
   output logic  gate_o,
   output logic  heartbeat_o,
   output logic  flash_o,
   output logic  gain_pwm_o
);

   logic [TIMER_BITS-1:0] timer;
   logic                  gate_bit_r;
   logic [GAIN_BITS:0]    pwm_acc;    // top bit is the carry out

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer      <= '0;
         gate_bit_r <= 1'b0;
         gate_o     <= 1'b0;
      end else begin
         timer      <= timer + 1'b1;
         gate_bit_r <= timer[GATE_BITS];
         gate_o     <= timer[GATE_BITS] & ~gate_bit_r; // rising edge of gate bit
      end
   end

   assign heartbeat_o = timer[GATE_BITS+1];

   // slow blink for the clock-change warning
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         flash_o <= 1'b0;
      end else if (timer[GATE_BITS+2]) begin
         flash_o <= ~timer[GATE_BITS];
      end
   end

   // first-order pwm, duty = gain/256
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwm_acc <= '0;
      end else begin
         pwm_acc <= {1'b0, pwm_acc[GAIN_BITS-1:0]} + {1'b0, gain_i};
      end
   end

   assign gain_pwm_o = pwm_acc[GAIN_BITS];

   a_gate_single: assert property (
      @(posedge clk_usb) disable iff (reset)
      gate_o |=> !gate_o
   ) else $error("gate strobe longer than one cycle");

endmodule

//--- clk_monitor_pkg.sv
package clk_monitor_pkg;

   // timing
   localparam int GATE_BITS  = 10;            // gate period is 2^(GATE_BITS+1) cycles
   localparam int TIMER_BITS = GATE_BITS + 3;
   localparam int HB_BIT     = 4;             // per-channel heartbeat tap

   // widths
   localparam int NUM_CLK_CH  = 3;            // 0 ext target, 1 adc feedback, 2 pll
   localparam int SAMPLE_BITS = 12;
   localparam int RATE_BITS   = 16;
   localparam int GAIN_BITS   = 8;

   typedef logic [SAMPLE_BITS-1:0] sample_t;
   typedef logic [RATE_BITS-1:0]   rate_t;
   typedef logic [GAIN_BITS-1:0]   gain_t;

   // one rate word per monitored clock
   typedef rate_t [NUM_CLK_CH-1:0] rate_vec_t;

   typedef enum logic [1:0] {
      LED_STATUS   = 2'd0,
      LED_TIMEBASE = 2'd1,
      LED_FEEDBACK = 2'd2,
      LED_PLL      = 2'd3
   } led_sel_e;

   typedef enum logic {
      TRIG_IDLE    = 1'b0,
      TRIG_ALLOWED = 1'b1
   } trig_state_e;

   typedef struct packed {
      led_sel_e led_select;
      logic     monitor_disable;   // clears and holds off the change flag
      rate_t    change_limit;
      gain_t    gain;
      sample_t  trig_level;        // msb picks above (1) or below (0)
      logic     use_adc;           // 0 = internal test counter
   } monitor_cfg_t;

endpackage
